// ==== common/mac_pkg.sv ====
// Widths, AXI4-Lite address map, opcodes and command word layout
// shared by the multiply-accumulate engine
package mac_pkg;

   // Datapath and register file
   localparam int data_width_lp     = 32;
   localparam int reg_els_lp        = 16;
   localparam int reg_addr_width_lp = 4;

   // Completion count as reported in status bits 31..8
   localparam int done_width_lp = 24;

   // Host address map, byte addresses
   localparam int axil_addr_width_lp = 8;
   localparam logic [axil_addr_width_lp-1:0] addr_reg_last_lp = 8'h3c;
   localparam logic [axil_addr_width_lp-1:0] addr_cmd_lp      = 8'h40;
   localparam logic [axil_addr_width_lp-1:0] addr_status_lp   = 8'h44;

   // Opcodes, value 3 behaves as multiply-add
   localparam int op_width_lp = 2;
   localparam logic [op_width_lp-1:0] op_mac_lp  = 2'd0;
   localparam logic [op_width_lp-1:0] op_add3_lp = 2'd1;
   localparam logic [op_width_lp-1:0] op_msub_lp = 2'd2;

   // Command word fields
   localparam int cmd_width_lp  = 18;
   localparam int cmd_op_lsb_lp = 16;
   localparam int cmd_rd_lsb_lp = 12;
   localparam int cmd_ra_lsb_lp = 8;
   localparam int cmd_rb_lsb_lp = 4;
   localparam int cmd_rc_lsb_lp = 0;

   // AXI response codes
   localparam logic [1:0] resp_okay_lp   = 2'b00;
   localparam logic [1:0] resp_slverr_lp = 2'b10;

endpackage

// ==== regfile/regfile_3r1w.sv ====
// Register file with three combinational read ports and one clocked write port
`timescale 1ns/1ps

module regfile_3r1w
  #(
   parameter int width_p = 32,
   parameter int els_p   = 16
  )
  (
   input  logic                     w_clk_i,

   input  logic                     w_v_i,
   input  logic [$clog2(els_p)-1:0] w_addr_i,
   input  logic [width_p-1:0]       w_data_i,

   input  logic [$clog2(els_p)-1:0] r0_addr_i,
   input  logic [$clog2(els_p)-1:0] r1_addr_i,
   input  logic [$clog2(els_p)-1:0] r2_addr_i,
   output logic [width_p-1:0]       r0_data_o,
   output logic [width_p-1:0]       r1_data_o,
   output logic [width_p-1:0]       r2_data_o
  );

   logic [width_p-1:0] mem [els_p];

   // Reads see the array directly, a write shows up after the edge
   assign r0_data_o = mem[r0_addr_i];
   assign r1_data_o = mem[r1_addr_i];
   assign r2_data_o = mem[r2_addr_i];

   always_ff @(posedge w_clk_i)
   begin
      if (w_v_i)
      begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // Writer must stay inside the array
   a_wr_addr_range: assert property (@(posedge w_clk_i)
      w_v_i |-> (32'(w_addr_i) < 32'(els_p)));

   // No X ever lands in a register
   a_wr_data_known: assert property (@(posedge w_clk_i)
      w_v_i |-> !$isunknown(w_data_i));

endmodule

// ==== source/axil_ctrl.sv ====
// AXI4-Lite slave: address decode, one internal action per cycle
// with reads first, and held write/read responses
`timescale 1ns/1ps

module axil_ctrl
  (
   input  logic                                 w_clk_i,
   input  logic                                 rst_n_i,

   input  logic                                 awvalid_i,
   output logic                                 awready_o,
   input  logic [mac_pkg::axil_addr_width_lp-1:0] awaddr_i,
   input  logic                                 wvalid_i,
   output logic                                 wready_o,
   input  logic [mac_pkg::data_width_lp-1:0]    wdata_i,
   output logic                                 bvalid_o,
   input  logic                                 bready_i,
   output logic [1:0]                           bresp_o,
   input  logic                                 arvalid_i,
   output logic                                 arready_o,
   input  logic [mac_pkg::axil_addr_width_lp-1:0] araddr_i,
   output logic                                 rvalid_o,
   input  logic                                 rready_i,
   output logic [mac_pkg::data_width_lp-1:0]    rdata_o,
   output logic [1:0]                           rresp_o,

   output logic [mac_pkg::reg_addr_width_lp-1:0] rd_addr_o,
   input  logic [mac_pkg::data_width_lp-1:0]    rd_data_i,

   output logic                                 host_wr_v_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] host_wr_addr_o,
   output logic [mac_pkg::data_width_lp-1:0]    host_wr_data_o,
   input  logic                                 host_wr_ready_i,

   output logic                                 cmd_v_o,
   output logic [mac_pkg::cmd_width_lp-1:0]     cmd_word_o,
   input  logic                                 cmd_ready_i,

   input  logic                                 busy_i,
   input  logic [mac_pkg::done_width_lp-1:0]    ops_done_i
  );

   import mac_pkg::*;

   logic                          wr_pend_q;
   logic [axil_addr_width_lp-1:0] wr_addr_q;
   logic [data_width_lp-1:0]      wr_data_q;
   logic                          bvalid_q;
   logic [1:0]                    bresp_q;
   logic                          rvalid_q;
   logic [data_width_lp-1:0]      rdata_q;
   logic [1:0]                    rresp_q;

   logic                          wr_go;
   logic                          wr_done;
   logic                          wr_is_reg;
   logic                          wr_is_cmd;
   logic                          rd_go;
   logic                          rd_is_reg;
   logic                          rd_is_status;
   logic [data_width_lp-1:0]      status_word;

   // Register window needs word-aligned addresses
   assign wr_is_reg    = (wr_addr_q[1:0] == 2'b00) && (wr_addr_q <= addr_reg_last_lp);
   assign wr_is_cmd    = wr_addr_q == addr_cmd_lp;
   assign rd_is_reg    = (araddr_i[1:0] == 2'b00) && (araddr_i <= addr_reg_last_lp);
   assign rd_is_status = araddr_i == addr_status_lp;

   assign status_word = {ops_done_i, {(data_width_lp-done_width_lp-1){1'b0}}, busy_i};

   // Read channel, blocked while a response waits
   assign rd_go     = arvalid_i && !rvalid_q;
   assign arready_o = rd_go;
   assign rd_addr_o = araddr_i[2 +: reg_addr_width_lp];

   // Address and data are taken in the same cycle
   assign wr_go     = awvalid_i && wvalid_i && !wr_pend_q && !bvalid_q;
   assign awready_o = wr_go;
   assign wready_o  = wr_go;

   // Pending write waits whenever a read takes the cycle
   assign host_wr_v_o    = wr_pend_q && wr_is_reg && !rd_go;
   assign host_wr_addr_o = wr_addr_q[2 +: reg_addr_width_lp];
   assign host_wr_data_o = wr_data_q;
   assign cmd_v_o        = wr_pend_q && wr_is_cmd && !rd_go;
   assign cmd_word_o     = wr_data_q[cmd_width_lp-1:0];

   // Unmapped writes finish at once with an error
   assign wr_done = (host_wr_v_o && host_wr_ready_i)
                  || (cmd_v_o && cmd_ready_i)
                  || (wr_pend_q && !wr_is_reg && !wr_is_cmd);

   always_ff @(posedge w_clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_pend_q <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
      end
      else
      begin
         if (wr_go)
            wr_pend_q <= 1'b1;
         else if (wr_done)
            wr_pend_q <= 1'b0;

         if (wr_done)
            bvalid_q <= 1'b1;
         else if (bready_i)
            bvalid_q <= 1'b0;

         if (rd_go)
            rvalid_q <= 1'b1;
         else if (rready_i)
            rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge w_clk_i)
   begin
      if (wr_go)
      begin
         wr_addr_q <= awaddr_i;
         wr_data_q <= wdata_i;
      end
      if (wr_done)
         bresp_q <= (wr_is_reg || wr_is_cmd) ? resp_okay_lp : resp_slverr_lp;
      if (rd_go)
      begin
         rdata_q <= rd_is_reg ? rd_data_i : (rd_is_status ? status_word : '0);
         // Command register is write only
         rresp_q <= (rd_is_reg || rd_is_status) ? resp_okay_lp : resp_slverr_lp;
      end
   end

   assign bvalid_o = bvalid_q;
   assign bresp_o  = bresp_q;
   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;
   assign rresp_o  = rresp_q;

   // Write response stays put until the host takes it
   a_b_hold: assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

// ==== source/mac_issue.sv ====
// Issue stage: command decode, scoreboard stall against execute
// and writeback, operand capture
`timescale 1ns/1ps

module mac_issue
  (
   input  logic                                  w_clk_i,
   input  logic                                  rst_n_i,

   input  logic                                  cmd_v_i,
   input  logic [mac_pkg::cmd_width_lp-1:0]      cmd_word_i,
   output logic                                  cmd_ready_o,

   output logic [mac_pkg::reg_addr_width_lp-1:0] ra_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] rb_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] rc_o,
   input  logic [mac_pkg::data_width_lp-1:0]     a_data_i,
   input  logic [mac_pkg::data_width_lp-1:0]     b_data_i,
   input  logic [mac_pkg::data_width_lp-1:0]     c_data_i,

   input  logic                                  ex_v_i,
   input  logic [mac_pkg::reg_addr_width_lp-1:0] ex_rd_i,
   input  logic                                  wb_v_i,
   input  logic [mac_pkg::reg_addr_width_lp-1:0] wb_rd_i,

   output logic                                  iss_v_o,
   output logic [mac_pkg::op_width_lp-1:0]       iss_op_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] iss_rd_o,
   output logic [mac_pkg::data_width_lp-1:0]     iss_a_o,
   output logic [mac_pkg::data_width_lp-1:0]     iss_b_o,
   output logic [mac_pkg::data_width_lp-1:0]     iss_c_o,

   output logic                                  busy_o
  );

   import mac_pkg::*;

   logic [op_width_lp-1:0]       op;
   logic [reg_addr_width_lp-1:0] rd;
   logic                         hit;
   logic                         go;

   assign op   = cmd_word_i[cmd_op_lsb_lp +: op_width_lp];
   assign rd   = cmd_word_i[cmd_rd_lsb_lp +: reg_addr_width_lp];
   assign ra_o = cmd_word_i[cmd_ra_lsb_lp +: reg_addr_width_lp];
   assign rb_o = cmd_word_i[cmd_rb_lsb_lp +: reg_addr_width_lp];
   assign rc_o = cmd_word_i[cmd_rc_lsb_lp +: reg_addr_width_lp];

   // Any register of the command still owed by an in-flight result
   assign hit = (ex_v_i && (ex_rd_i == rd || ex_rd_i == ra_o
                            || ex_rd_i == rb_o || ex_rd_i == rc_o))
             || (wb_v_i && (wb_rd_i == rd || wb_rd_i == ra_o
                            || wb_rd_i == rb_o || wb_rd_i == rc_o));

   assign cmd_ready_o = !hit;
   assign go          = cmd_v_i && cmd_ready_o;

   always_ff @(posedge w_clk_i)
   begin
      if (!rst_n_i)
         iss_v_o <= 1'b0;
      else
         iss_v_o <= go;
   end

   // Operands come straight off the async read ports
   always_ff @(posedge w_clk_i)
   begin
      if (go)
      begin
         iss_op_o <= op;
         iss_rd_o <= rd;
         iss_a_o  <= a_data_i;
         iss_b_o  <= b_data_i;
         iss_c_o  <= c_data_i;
      end
   end

   assign busy_o = iss_v_o || wb_v_i;

endmodule

// ==== source/mac_execute.sv ====
// Execute and writeback stages, register-file write arbitration
// and completed-command counter
`timescale 1ns/1ps

module mac_execute
  (
   input  logic                                  w_clk_i,
   input  logic                                  rst_n_i,

   input  logic                                  iss_v_i,
   input  logic [mac_pkg::op_width_lp-1:0]       iss_op_i,
   input  logic [mac_pkg::reg_addr_width_lp-1:0] iss_rd_i,
   input  logic [mac_pkg::data_width_lp-1:0]     iss_a_i,
   input  logic [mac_pkg::data_width_lp-1:0]     iss_b_i,
   input  logic [mac_pkg::data_width_lp-1:0]     iss_c_i,

   output logic                                  ex_v_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] ex_rd_o,
   output logic                                  wb_v_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] wb_rd_o,

   input  logic                                  host_wr_v_i,
   input  logic [mac_pkg::reg_addr_width_lp-1:0] host_wr_addr_i,
   input  logic [mac_pkg::data_width_lp-1:0]     host_wr_data_i,
   output logic                                  host_wr_ready_o,

   output logic                                  rf_w_v_o,
   output logic [mac_pkg::reg_addr_width_lp-1:0] rf_w_addr_o,
   output logic [mac_pkg::data_width_lp-1:0]     rf_w_data_o,

   output logic [mac_pkg::done_width_lp-1:0]     ops_done_o
  );

   import mac_pkg::*;

   logic [data_width_lp-1:0] prod;
   logic [data_width_lp-1:0] result;
   logic [data_width_lp-1:0] wb_data_q;

   // Low word of the product is all any opcode needs
   assign prod = iss_a_i * iss_b_i;

   always_comb
   begin
      case (iss_op_i)
         op_add3_lp: result = iss_a_i + iss_b_i + iss_c_i;
         op_msub_lp: result = iss_c_i - prod;
         default:    result = prod + iss_c_i;
      endcase
   end

   assign ex_v_o  = iss_v_i;
   assign ex_rd_o = iss_rd_i;

   always_ff @(posedge w_clk_i)
   begin
      if (!rst_n_i)
      begin
         wb_v_o     <= 1'b0;
         ops_done_o <= '0;
      end
      else
      begin
         wb_v_o <= iss_v_i;
         // Counted when the result reaches the register file
         if (wb_v_o)
            ops_done_o <= ops_done_o + 1'b1;
      end
   end

   always_ff @(posedge w_clk_i)
   begin
      if (iss_v_i)
      begin
         wb_rd_o   <= iss_rd_i;
         wb_data_q <= result;
      end
   end

   // Writeback owns the port, host writes fill the gaps
   assign host_wr_ready_o = !wb_v_o;
   assign rf_w_v_o        = wb_v_o || host_wr_v_i;
   assign rf_w_addr_o     = wb_v_o ? wb_rd_o : host_wr_addr_i;
   assign rf_w_data_o     = wb_v_o ? wb_data_q : host_wr_data_i;

   // A host write granted under a command bound for the same register
   // would be overwritten by that result one cycle later
   a_no_host_over_wb: assert property (@(posedge w_clk_i) disable iff (!rst_n_i)
      host_wr_v_i && host_wr_ready_o |-> !(iss_v_i && iss_rd_i == host_wr_addr_i));

endmodule

// ==== source/mac_engine_top.sv ====
// Engine top: AXI4-Lite controller, register file, issue and execute stages
`timescale 1ns/1ps

module mac_engine_top
  (
   input  logic                                   w_clk_i,
   input  logic                                   rst_n_i,

   input  logic                                   awvalid_i,
   output logic                                   awready_o,
   input  logic [mac_pkg::axil_addr_width_lp-1:0] awaddr_i,
   input  logic                                   wvalid_i,
   output logic                                   wready_o,
   input  logic [mac_pkg::data_width_lp-1:0]      wdata_i,
   output logic                                   bvalid_o,
   input  logic                                   bready_i,
   output logic [1:0]                             bresp_o,
   input  logic                                   arvalid_i,
   output logic                                   arready_o,
   input  logic [mac_pkg::axil_addr_width_lp-1:0] araddr_i,
   output logic                                   rvalid_o,
   input  logic                                   rready_i,
   output logic [mac_pkg::data_width_lp-1:0]      rdata_o,
   output logic [1:0]                             rresp_o
  );

   import mac_pkg::*;

   logic [reg_addr_width_lp-1:0] rd_addr;
   logic [reg_addr_width_lp-1:0] r0_addr;
   logic [data_width_lp-1:0]     r0_data;
   logic [data_width_lp-1:0]     r1_data;
   logic [data_width_lp-1:0]     r2_data;
   logic [reg_addr_width_lp-1:0] ra;
   logic [reg_addr_width_lp-1:0] rb;
   logic [reg_addr_width_lp-1:0] rc;

   logic                         host_wr_v;
   logic [reg_addr_width_lp-1:0] host_wr_addr;
   logic [data_width_lp-1:0]     host_wr_data;
   logic                         host_wr_ready;
   logic                         cmd_v;
   logic [cmd_width_lp-1:0]      cmd_word;
   logic                         cmd_ready;
   logic                         busy;
   logic [done_width_lp-1:0]     ops_done;

   logic                         iss_v;
   logic [op_width_lp-1:0]       iss_op;
   logic [reg_addr_width_lp-1:0] iss_rd;
   logic [data_width_lp-1:0]     iss_a;
   logic [data_width_lp-1:0]     iss_b;
   logic [data_width_lp-1:0]     iss_c;
   logic                         ex_v;
   logic [reg_addr_width_lp-1:0] ex_rd;
   logic                         wb_v;
   logic [reg_addr_width_lp-1:0] wb_rd;
   logic                         rf_w_v;
   logic [reg_addr_width_lp-1:0] rf_w_addr;
   logic [data_width_lp-1:0]     rf_w_data;

   // Port 0 goes to issue while a command is offered
   assign r0_addr = cmd_v ? ra : rd_addr;

   axil_ctrl i_axil_ctrl (
      .w_clk_i, .rst_n_i,
      .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
      .bvalid_o, .bready_i, .bresp_o,
      .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
      .rd_addr_o(rd_addr), .rd_data_i(r0_data),
      .host_wr_v_o(host_wr_v), .host_wr_addr_o(host_wr_addr),
      .host_wr_data_o(host_wr_data), .host_wr_ready_i(host_wr_ready),
      .cmd_v_o(cmd_v), .cmd_word_o(cmd_word), .cmd_ready_i(cmd_ready),
      .busy_i(busy), .ops_done_i(ops_done)
   );

   regfile_3r1w #(.width_p(data_width_lp), .els_p(reg_els_lp)) i_regfile (
      .w_clk_i,
      .w_v_i(rf_w_v), .w_addr_i(rf_w_addr), .w_data_i(rf_w_data),
      .r0_addr_i(r0_addr), .r1_addr_i(rb), .r2_addr_i(rc),
      .r0_data_o(r0_data), .r1_data_o(r1_data), .r2_data_o(r2_data)
   );

   mac_issue i_mac_issue (
      .w_clk_i, .rst_n_i,
      .cmd_v_i(cmd_v), .cmd_word_i(cmd_word), .cmd_ready_o(cmd_ready),
      .ra_o(ra), .rb_o(rb), .rc_o(rc),
      .a_data_i(r0_data), .b_data_i(r1_data), .c_data_i(r2_data),
      .ex_v_i(ex_v), .ex_rd_i(ex_rd), .wb_v_i(wb_v), .wb_rd_i(wb_rd),
      .iss_v_o(iss_v), .iss_op_o(iss_op), .iss_rd_o(iss_rd),
      .iss_a_o(iss_a), .iss_b_o(iss_b), .iss_c_o(iss_c),
      .busy_o(busy)
   );

   mac_execute i_mac_execute (
      .w_clk_i, .rst_n_i,
      .iss_v_i(iss_v), .iss_op_i(iss_op), .iss_rd_i(iss_rd),
      .iss_a_i(iss_a), .iss_b_i(iss_b), .iss_c_i(iss_c),
      .ex_v_o(ex_v), .ex_rd_o(ex_rd), .wb_v_o(wb_v), .wb_rd_o(wb_rd),
      .host_wr_v_i(host_wr_v), .host_wr_addr_i(host_wr_addr),
      .host_wr_data_i(host_wr_data), .host_wr_ready_o(host_wr_ready),
      .rf_w_v_o(rf_w_v), .rf_w_addr_o(rf_w_addr), .rf_w_data_o(rf_w_data),
      .ops_done_o(ops_done)
   );

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock of 10 ns period and an active-low reset held for two cycles
`timescale 1ns/1ps

module tb_clk_gen
  (
   output logic clk_o,
   output logic rst_n_o
  );

   initial
   begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // Released on a falling edge, like every other input
   initial
   begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// ==== dv/tb_mac_engine.sv ====
// Testbench for the MAC engine: AXI4-Lite driver tasks, shadow registers
// with a reference function, comparing process and watchdog
`timescale 1ns/1ps

module tb_mac_engine;

   import mac_pkg::*;

   localparam int n_mac_lp    = 8;
   localparam int n_mix_lp    = 8;
   localparam int n_chain_lp  = 6;
   localparam int resp_wait_lp = 100;
   // One write pass, three readbacks, the commands, two status reads and three error accesses
   localparam int n_txn_lp = 4 * reg_els_lp + 2 * n_mac_lp + 2 * n_mix_lp + n_chain_lp + 5;

   logic        clk;
   logic        rst_n;
   logic        awvalid;
   logic        awready;
   logic [7:0]  awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [7:0]  araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;

   logic [31:0] shadow [reg_els_lp];
   integer      seed;
   int          errors;
   int          cmds_issued;
   string       name_q [$];
   logic [31:0] exp_q [$];
   logic [31:0] act_q [$];
   string       cmp_name;
   logic [31:0] cmp_exp;
   logic [31:0] cmp_act;

   tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   mac_engine_top i_mac_engine_top (
      .w_clk_i(clk), .rst_n_i(rst_n),
      .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr),
      .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata),
      .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp),
      .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr),
      .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp)
   );

   // Low 32 bits of the full product, then the opcode rule
   function automatic logic [31:0] mac_ref(input logic [1:0] op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] c);
      logic [63:0] prod;
      prod = {32'd0, a} * {32'd0, b};
      case (op)
         op_add3_lp: return a + b + c;
         op_msub_lp: return c - prod[31:0];
         default:    return prod[31:0] + c;
      endcase
   endfunction

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      int wait_cycles;
      wait_cycles = 0;
      resp = 2'bxx;
      @(negedge clk);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = addr;
      wdata   = data;
      #1;
      while (!(awready && wready))
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'($random(seed));
      #1;
      while (!(bvalid && bready) && wait_cycles < resp_wait_lp)
      begin
         @(negedge clk);
         bready = 1'($random(seed));
         #1;
         wait_cycles++;
      end
      if (!(bvalid && bready))
      begin
         $display("ERROR: no write response for address 0x%h", addr);
         errors++;
      end
      else
      begin
         resp = bresp;
         @(negedge clk);
         if (bvalid)
         begin
            $display("ERROR: write response for address 0x%h was repeated", addr);
            errors++;
         end
      end
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int wait_cycles;
      wait_cycles = 0;
      data = 'x;
      resp = 2'bxx;
      @(negedge clk);
      arvalid = 1'b1;
      araddr  = addr;
      #1;
      while (!arready)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
      rready  = 1'($random(seed));
      #1;
      while (!(rvalid && rready) && wait_cycles < resp_wait_lp)
      begin
         @(negedge clk);
         rready = 1'($random(seed));
         #1;
         wait_cycles++;
      end
      if (!(rvalid && rready))
      begin
         $display("ERROR: no read response for address 0x%h", addr);
         errors++;
      end
      else
      begin
         data = rdata;
         resp = rresp;
         @(negedge clk);
         if (rvalid)
         begin
            $display("ERROR: read response for address 0x%h was repeated", addr);
            errors++;
         end
      end
      rready = 1'b0;
   endtask

   task automatic queue_result(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   task automatic expect_okay(input string what, input logic [1:0] resp);
      if (resp !== resp_okay_lp)
      begin
         $display("ERROR: unexpected error response on %s", what);
         errors++;
      end
   endtask

   task automatic compare_reg(input string name, input logic [3:0] idx);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(8'(idx) << 2, data, resp);
      expect_okay(name, resp);
      queue_result(name, shadow[idx], data);
   endtask

   task automatic compare_status(input string name);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(addr_status_lp, data, resp);
      expect_okay(name, resp);
      // Idle engine, count in the upper bits
      queue_result(name, {24'(cmds_issued), 7'd0, 1'b0}, data);
   endtask

   task automatic run_cmd(input logic [1:0] op, input logic [3:0] rd, input logic [3:0] ra,
                          input logic [3:0] rb, input logic [3:0] rc);
      logic [31:0] word;
      logic [1:0]  resp;
      word = (32'(op) << cmd_op_lsb_lp) | (32'(rd) << cmd_rd_lsb_lp)
           | (32'(ra) << cmd_ra_lsb_lp) | (32'(rb) << cmd_rb_lsb_lp)
           | (32'(rc) << cmd_rc_lsb_lp);
      axil_write(addr_cmd_lp, word, resp);
      expect_okay("command write", resp);
      shadow[rd] = mac_ref(op, shadow[ra], shadow[rb], shadow[rc]);
      cmds_issued++;
   endtask

   // Every read result is checked here against its expected value
   always @(posedge clk)
   begin
      while (act_q.size() > 0)
      begin
         cmp_name = name_q.pop_front();
         cmp_exp  = exp_q.pop_front();
         cmp_act  = act_q.pop_front();
         if (cmp_act !== cmp_exp)
         begin
            $display("MISMATCH %s: expected 0x%h, actual 0x%h", cmp_name, cmp_exp, cmp_act);
            errors++;
         end
      end
   end

   initial
   begin
      repeat (200 * n_txn_lp) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles", 200 * n_txn_lp);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0] data;
      logic [1:0]  resp;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [3:0]  rc;
      seed        = 32'hc533c828;
      errors      = 0;
      cmds_issued = 0;
      awvalid     = 1'b0;
      awaddr      = '0;
      wvalid      = 1'b0;
      wdata       = '0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      araddr      = '0;
      rready      = 1'b0;
      @(posedge rst_n);

      // Register window
      for (int i = 0; i < reg_els_lp; i++)
      begin
         data = $random(seed);
         axil_write(8'(i * 4), data, resp);
         expect_okay("register write", resp);
         shadow[i] = data;
      end
      for (int i = 0; i < reg_els_lp; i++)
         compare_reg("register readback", 4'(i));
      compare_status("status after writes");

      // Multiply-add, opcode 3 included
      for (int i = 0; i < n_mac_lp; i++)
      begin
         rd = 4'($random(seed));
         ra = 4'($random(seed));
         rb = 4'($random(seed));
         rc = 4'($random(seed));
         run_cmd(i[0] ? 2'd3 : op_mac_lp, rd, ra, rb, rc);
         compare_reg("mac result", rd);
      end

      // Three-way add and multiply-subtract, some overwrite source a
      for (int i = 0; i < n_mix_lp; i++)
      begin
         ra = 4'($random(seed));
         rb = 4'($random(seed));
         rc = 4'($random(seed));
         rd = i[1] ? ra : 4'($random(seed));
         run_cmd(i[0] ? op_msub_lp : op_add3_lp, rd, ra, rb, rc);
         compare_reg(i[0] ? "msub result" : "add3 result", rd);
      end

      // Dependent chain, each command reads the previous destination
      rd = 4'($random(seed));
      for (int i = 0; i < n_chain_lp; i++)
      begin
         ra = rd;
         rb = 4'($random(seed));
         rc = 4'($random(seed));
         rd = 4'($random(seed));
         run_cmd(2'(i % 3), rd, ra, rb, rc);
      end
      for (int i = 0; i < reg_els_lp; i++)
         compare_reg("chain readback", 4'(i));

      // Completion count and error responses
      compare_status("status count");
      axil_write(8'h80, 32'h0, resp);
      queue_result("unmapped write resp", {30'd0, resp_slverr_lp}, {30'd0, resp});
      axil_read(8'h48, data, resp);
      queue_result("unmapped read resp", {30'd0, resp_slverr_lp}, {30'd0, resp});
      axil_read(addr_cmd_lp, data, resp);
      queue_result("command read resp", {30'd0, resp_slverr_lp}, {30'd0, resp});

      // Nothing lost after all the back-pressure
      for (int i = 0; i < reg_els_lp; i++)
         compare_reg("final readback", 4'(i));

      @(posedge clk);
      @(negedge clk);
      $display("Run finished with %0d errors over %0d commands", errors, cmds_issued);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== tb.f ====
common/mac_pkg.sv
regfile/regfile_3r1w.sv
source/axil_ctrl.sv
source/mac_issue.sv
source/mac_execute.sv
source/mac_engine_top.sv
dv/tb_clk_gen.sv
dv/tb_mac_engine.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINT     := --lint-only -Wall --timing
TOP      := tb_mac_engine
RTL_TOP  := mac_engine_top
FILELIST := tb.f
OBJ_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(TOOL) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
